//--- compile.f
+incdir+common
common/panel_pkg.sv
common/cmd_pkg.sv
design/cmd_decoder.sv
fill_engine/cmd_fill_control.sv
fill_engine/fill_area_walker.sv
design/frame_buffer.sv
design/panel_draw_top.sv
verif/tb_clock_gen.sv
verif/panel_draw_checks.sv
verif/panel_draw_tb.sv

//--- verif/panel_draw_tb.sv
// Panel drawing testbench

`include "panel_cfg.svh"

module panel_draw_tb;
    import panel_pkg::*;
    import cmd_pkg::*;

    localparam int clk_period    = 8;
    localparam int panel_w       = `PANEL_WIDTH;
    localparam int panel_h       = `PANEL_HEIGHT;
    localparam int num_cmds      = 13;
    localparam int num_readbacks = 10;

    logic            clk;
    logic            reset;
    logic            cmd_valid;
    host_cmd_t       cmd;
    logic            busy;
    logic            done;
    row_t            rd_row;
    column_t         rd_column;
    pixel_sel_t      rd_pixel;
    logic [7:0]      rd_data;
    logic [8*16-1:0] test_name;
    logic            exp_accept;
    logic [31:0]     exp_latency;
    logic            exp_valid;
    logic [7:0]      exp_data;
    logic            failed;
    logic            commands_built = 1'b0;
    integer          seed = 65528;
    int              limit_cycles;
    host_cmd_t       cmd_list [num_cmds];
    logic [7:0]      frame_model [`PANEL_HEIGHT][`PANEL_WIDTH][`BYTES_PER_PIXEL];

    tb_clock_gen u_clock (.clk(clk), .reset(reset));

    panel_draw_top u_dut (
        .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd), .busy(busy), .done(done),
        .rd_row(rd_row), .rd_column(rd_column), .rd_pixel(rd_pixel), .rd_data(rd_data)
    );

    panel_draw_checks u_checks (
        .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .busy(busy), .done(done),
        .rd_row(rd_row), .rd_column(rd_column), .rd_pixel(rd_pixel), .rd_data(rd_data),
        .test_name(test_name), .exp_accept(exp_accept), .exp_latency(exp_latency),
        .exp_valid(exp_valid), .exp_data(exp_data), .failed(failed)
    );

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic host_cmd_t make_fill(input int x, input int y, input int w, input int h);
        host_cmd_t c;
        c.opcode = op_fill;
        c.x1     = column_t'(x);
        c.y1     = row_t'(y);
        c.width  = width_t'(w);
        c.height = height_t'(h);
        c.color  = 24'($random(seed));
        return c;
    endfunction

    // ******************************
    // reference model
    // ******************************
    task automatic clip_command(input host_cmd_t c, output bit ok, output int x, y, w, h,
                                output logic [23:0] color);
        if (c.opcode == op_blank) begin
            ok = 1'b1;
            x = 0;
            y = 0;
            w = panel_w;
            h = panel_h;
            color = '0;
        end else begin
            x = int'(c.x1);
            y = int'(c.y1);
            color = c.color;
            ok = (x < panel_w) && (y < panel_h) && (c.width != 0) && (c.height != 0);
            w = (int'(c.width) > panel_w - x) ? panel_w - x : int'(c.width);
            h = (int'(c.height) > panel_h - y) ? panel_h - y : int'(c.height);
        end
    endtask

    task automatic paint_model(input int x, y, w, h, input logic [23:0] color);
        for (int r = y; r < y + h; r++) begin
            for (int c = x; c < x + w; c++) begin
                frame_model[r][c][0] = color[23:16];    // red is byte 0
                frame_model[r][c][1] = color[15:8];
                frame_model[r][c][2] = color[7:0];
            end
        end
    endtask

    task automatic build_commands();
        bit          ok;
        int          x, y, w, h;
        int          px, py;
        int          area_total;
        logic [23:0] color;
        area_total = 0;
        cmd_list[0] = make_fill(3, 3, 4, 4);
        cmd_list[0].opcode = op_blank;    // color and corner must be ignored
        for (int i = 1; i <= 4; i++) begin
            px = rnd(panel_w);
            py = rnd(panel_h);
            cmd_list[i] = make_fill(px, py, 1 + rnd(panel_w - px), 1 + rnd(panel_h - py));
        end
        px = 24 + rnd(8);
        cmd_list[5] = make_fill(px, rnd(12), panel_w - px + 1 + rnd(8), 1 + rnd(4));
        py = 10 + rnd(6);
        cmd_list[6] = make_fill(rnd(24), py, 1 + rnd(8), panel_h - py + 1 + rnd(8));
        cmd_list[7] = make_fill(28 + rnd(4), 12 + rnd(4), 63, 31);
        cmd_list[8] = make_fill(rnd(panel_w), rnd(panel_h), 0, 1 + rnd(panel_h));
        cmd_list[9] = make_fill(rnd(panel_w), rnd(panel_h), 1 + rnd(panel_w), 0);
        cmd_list[10] = make_fill(rnd(panel_w), rnd(panel_h), 0, 0);
        for (int i = 11; i <= 12; i++) begin
            px = rnd(panel_w);
            py = rnd(panel_h);
            cmd_list[i] = make_fill(px, py, 1 + rnd(panel_w - px), 1 + rnd(panel_h - py));
        end
        // the last command is strobed while busy and never runs
        for (int i = 0; i < num_cmds - 1; i++) begin
            clip_command(cmd_list[i], ok, x, y, w, h, color);
            if (ok) begin
                area_total += w * h;
            end
        end
        // a full readback costs 3 cycles per pixel like a write
        limit_cycles = 3 * (area_total + num_readbacks * panel_w * panel_h) +
                       16 * num_cmds + 200;
    endtask

    // ******************************
    // stimulus tasks
    // ******************************
    task automatic strobe_command(input host_cmd_t c, input bit accept, input int latency);
        @(posedge clk);
        #1;
        cmd         = c;
        cmd_valid   = 1'b1;
        exp_accept  = accept;
        exp_latency = latency;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_done();
        while (!done) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);    // busy falls here
        #1;
    endtask

    task automatic run_command(input host_cmd_t c, input bit overlap, input host_cmd_t extra);
        bit          ok;
        int          x, y, w, h;
        logic [23:0] color;
        clip_command(c, ok, x, y, w, h, color);
        strobe_command(c, ok, 3 * w * h + 5);
        if (ok) begin
            paint_model(x, y, w, h, color);
            if (overlap) begin
                strobe_command(extra, 1'b0, 0);
            end
            wait_done();
            if (overlap) begin
                repeat (10) @(posedge clk);    // room for a stray second done
            end
        end else begin
            repeat (8) @(posedge clk);
        end
    endtask

    task automatic check_frame();
        for (int r = 0; r < panel_h; r++) begin
            for (int c = 0; c < panel_w; c++) begin
                for (int b = 0; b < `BYTES_PER_PIXEL; b++) begin
                    @(posedge clk);
                    #1;
                    rd_row    = row_t'(r);
                    rd_column = column_t'(c);
                    rd_pixel  = pixel_sel_t'(b);
                    exp_valid = 1'b1;
                    exp_data  = frame_model[r][c][b];
                end
            end
        end
        @(posedge clk);
        #1;
        exp_valid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
    endtask

    // ******************************
    // watchdog and failure stop
    // ******************************
    initial begin
        wait (commands_built);
        #(limit_cycles * clk_period);
        $display("=== FAIL ===");
        $fatal(1, "timeout after %0d cycles, the DUT never finished", limit_cycles);
    end

    initial begin
        wait (failed);
        $display("=== FAIL ===");
        $fatal(1, "stopping at the first failed check");
    end

    initial begin
        cmd_valid   = 1'b0;
        cmd         = '0;
        rd_row      = '0;
        rd_column   = '0;
        rd_pixel    = '0;
        exp_accept  = 1'b0;
        exp_latency = '0;
        exp_valid   = 1'b0;
        exp_data    = '0;
        test_name   = "reset";
        build_commands();
        commands_built = 1'b1;
        @(negedge reset);

        test_name = "blank";
        run_command(cmd_list[0], 1'b0, cmd_list[0]);
        check_frame();
        test_name = "fill_random";
        for (int i = 1; i <= 4; i++) begin
            run_command(cmd_list[i], 1'b0, cmd_list[i]);
            check_frame();
        end
        test_name = "clip_edges";
        for (int i = 5; i <= 7; i++) begin
            run_command(cmd_list[i], 1'b0, cmd_list[i]);
            check_frame();
        end
        test_name = "drop_empty";
        for (int i = 8; i <= 10; i++) begin
            run_command(cmd_list[i], 1'b0, cmd_list[i]);
        end
        check_frame();
        test_name = "busy_ignore";
        run_command(cmd_list[11], 1'b1, cmd_list[12]);
        check_frame();

        if (failed) begin
            $display("=== FAIL ===");
            $fatal(1, "a check failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- verif/panel_draw_checks.sv
// Port checks for the panel drawing path

module panel_draw_checks (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  logic                  busy,
    input  logic                  done,
    input  panel_pkg::row_t       rd_row,
    input  panel_pkg::column_t    rd_column,
    input  panel_pkg::pixel_sel_t rd_pixel,
    input  logic [7:0]            rd_data,
    input  logic [8*16-1:0]       test_name,
    input  logic                  exp_accept,
    input  logic [31:0]           exp_latency,
    input  logic                  exp_valid,
    input  logic [7:0]            exp_data,
    output logic                  failed
);
    import panel_pkg::*;

    int          cycle;
    int          start_cycle;
    logic [31:0] latency_q;
    logic        pending;
    logic        reset_q;
    logic        busy_q;
    logic        done_q;
    logic        exp_valid_q;
    logic [7:0]  exp_data_q;
    row_t        row_q;
    column_t     column_q;
    pixel_sel_t  pixel_q;

    initial begin
        failed  = 1'b0;
        cycle   = 0;
        pending = 1'b0;
    end

    always @(posedge clk) begin
        cycle       <= cycle + 1;
        reset_q     <= reset;
        busy_q      <= busy;
        done_q      <= done;
        exp_valid_q <= exp_valid;
        exp_data_q  <= exp_data;
        row_q       <= rd_row;
        column_q    <= rd_column;
        pixel_q     <= rd_pixel;
        if (!reset) begin
            // ******************************
            // busy and done protocol
            // ******************************
            if (reset_q) begin
                assert (!busy && !done) else begin
                    $display("** Error [%0s] busy or done is high right after reset", test_name);
                    failed = 1'b1;
                end
            end
            if (cmd_valid && !busy) begin
                start_cycle <= cycle;    // a strobe while busy never starts anything
                latency_q   <= exp_latency;
                pending     <= exp_accept;
            end
            assert (!(busy && !busy_q && !pending)) else begin
                $display("** Error [%0s] busy rose for a command that should be dropped",
                         test_name);
                failed = 1'b1;
            end
            assert (!(done && done_q)) else begin
                $display("** Error [%0s] done stayed high for more than one cycle", test_name);
                failed = 1'b1;
            end
            assert (!done || (busy && pending)) else begin
                $display("** Error [%0s] done pulse without an accepted command", test_name);
                failed = 1'b1;
            end
            if (done && pending) begin
                assert (cycle - start_cycle == int'(latency_q)) else begin
                    $display("** Error [%0s] latency: expected %0d, actual %0d",
                             test_name, latency_q, cycle - start_cycle);
                    failed = 1'b1;
                end
                pending <= 1'b0;
            end
            assert (!done_q || !busy) else begin
                $display("** Error [%0s] busy did not fall in the cycle after done", test_name);
                failed = 1'b1;
            end

            // ******************************
            // frame readback
            // ******************************
            if (exp_valid_q) begin
                assert (rd_data == exp_data_q) else begin
                    $display("** Error [%0s] row %0d col %0d byte %0d: expected %02h, actual %02h",
                             test_name, row_q, column_q, pixel_q, exp_data_q, rd_data);
                    failed = 1'b1;
                end
            end
        end
    end

endmodule

//--- verif/tb_clock_gen.sv
// Testbench clock and reset

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    localparam int period       = 8;
    localparam int reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;    // released just after an edge like every other input
    end

endmodule

//--- design/panel_draw_top.sv
// Panel drawing command path

module panel_draw_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  cmd_pkg::host_cmd_t    cmd,
    output logic                  busy,
    output logic                  done,
    input  panel_pkg::row_t       rd_row,
    input  panel_pkg::column_t    rd_column,
    input  panel_pkg::pixel_sel_t rd_pixel,
    output logic [7:0]            rd_data
);
    import panel_pkg::*;
    import cmd_pkg::*;

    logic       req_valid;
    fill_req_t  req;
    logic       walk_enable;
    logic       walk_reset;
    fill_req_t  walk_req;
    logic       walk_done;
    mem_write_t wr;

    cmd_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .done      (done),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy)
    );

    cmd_fill_control u_control (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .walk_enable (walk_enable),
        .walk_reset  (walk_reset),
        .walk_req    (walk_req),
        .walk_done   (walk_done),
        .done        (done)
    );

    fill_area_walker u_walker (
        .clk        (clk),
        .reset      (reset),
        .enable     (walk_enable),
        .walk_reset (walk_reset),
        .req        (walk_req),
        .wr         (wr),
        .walk_done  (walk_done)
    );

    frame_buffer u_frame (
        .clk       (clk),
        .wr        (wr),
        .rd_row    (rd_row),
        .rd_column (rd_column),
        .rd_pixel  (rd_pixel),
        .rd_data   (rd_data)
    );

endmodule

//--- design/frame_buffer.sv
// Pixel frame buffer

`include "panel_cfg.svh"

module frame_buffer (
    input  logic                  clk,
    input  panel_pkg::mem_write_t wr,
    input  panel_pkg::row_t       rd_row,
    input  panel_pkg::column_t    rd_column,
    input  panel_pkg::pixel_sel_t rd_pixel,
    output logic [7:0]            rd_data
);
    import panel_pkg::*;

    // one byte per color channel of each pixel
    logic [7:0] mem [`PANEL_HEIGHT][`PANEL_WIDTH][`BYTES_PER_PIXEL];

    logic wr_in_range;

    // byte select has spare codes beyond the last channel
    assign wr_in_range = (wr.pixel < pixel_sel_t'(`BYTES_PER_PIXEL));

    // ******************************
    // write port
    // ******************************
    always_ff @(posedge clk) begin
        if (wr.we && wr_in_range) begin
            mem[wr.row][wr.column][wr.pixel] <= wr.data;
        end
    end

    // ******************************
    // scanout read port
    // ******************************
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_row][rd_column][rd_pixel];    // data shows up one cycle later
    end

endmodule

//--- fill_engine/fill_area_walker.sv
// Rectangle fill walker

`include "panel_cfg.svh"

module fill_area_walker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  logic                 walk_reset,
    input  cmd_pkg::fill_req_t   req,
    output panel_pkg::mem_write_t wr,
    output logic                 walk_done
);
    import panel_pkg::*;
    import cmd_pkg::*;

    pixel_sel_t pix_cnt;     // byte within the pixel
    column_t    col_cnt;     // column offset from x1
    row_t       row_cnt;     // row offset from y1
    logic       all_issued;
    logic       last_pixel;
    logic       last_column;
    logic       last_row;
    logic [7:0] byte_data;

    // ******************************
    // end of each counter
    // ******************************
    assign last_pixel  = (pix_cnt == pixel_sel_t'(`BYTES_PER_PIXEL - 1));
    assign last_column = (width_t'(col_cnt) == req.width - width_t'(1));
    assign last_row    = (height_t'(row_cnt) == req.height - height_t'(1));

    // byte 0 carries red
    always_comb begin
        case (pix_cnt)
            2'd0:    byte_data = req.color.red;
            2'd1:    byte_data = req.color.green;
            default: byte_data = req.color.blue;
        endcase
    end

    // ******************************
    // walk and write
    // ******************************
    always_ff @(posedge clk) begin
        if (reset || walk_reset) begin
            pix_cnt    <= '0;
            col_cnt    <= '0;
            row_cnt    <= '0;
            all_issued <= 1'b0;
            walk_done  <= 1'b0;
            wr.we      <= 1'b0;
        end else begin
            wr.we <= 1'b0;
            if (enable && !all_issued) begin
                wr.row    <= req.y1 + row_cnt;
                wr.column <= req.x1 + col_cnt;
                wr.pixel  <= pix_cnt;
                wr.data   <= byte_data;
                wr.we     <= 1'b1;

                if (!last_pixel) begin
                    pix_cnt <= pix_cnt + 1'b1;
                end else begin
                    pix_cnt <= '0;
                    if (!last_column) begin
                        col_cnt <= col_cnt + 1'b1;
                    end else begin
                        col_cnt <= '0;
                        if (!last_row) begin
                            row_cnt <= row_cnt + 1'b1;
                        end else begin
                            row_cnt    <= '0;
                            all_issued <= 1'b1;    // that was the final byte
                        end
                    end
                end
            end

            // the cycle after the final write shows done, held until walk_reset
            if (all_issued) begin
                walk_done <= 1'b1;
            end
        end
    end

endmodule

//--- fill_engine/cmd_fill_control.sv
// Fill request sequencer

module cmd_fill_control (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  cmd_pkg::fill_req_t req,
    output logic               walk_enable,
    output logic               walk_reset,
    output cmd_pkg::fill_req_t walk_req,
    input  logic               walk_done,
    output logic               done
);
    typedef enum logic [1:0] {
        st_start,
        st_running,
        st_predone,
        st_done
    } ctrl_state_t;

    ctrl_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_start;
            walk_enable <= 1'b0;
            walk_reset  <= 1'b0;
            done        <= 1'b0;
        end else begin
            case (state)
                st_start: begin
                    if (req_valid) begin
                        walk_enable <= 1'b1;
                        state       <= st_running;
                    end
                end
                st_running: begin
                    if (walk_done) begin
                        walk_enable <= 1'b0;
                        state       <= st_predone;
                    end
                end
                st_predone: begin
                    done       <= 1'b1;
                    walk_reset <= 1'b1;    // walker drops walk_done on this pulse
                    state      <= st_done;
                end
                st_done: begin
                    done       <= 1'b0;
                    walk_reset <= 1'b0;
                    state      <= st_start;
                end
                default: state <= st_start;
            endcase
        end
    end

    // the request is held for the whole walk
    always_ff @(posedge clk) begin
        if (state == st_start && req_valid) begin
            walk_req <= req;
        end
    end

endmodule

//--- design/cmd_decoder.sv
// Host command decoder

`include "panel_cfg.svh"

module cmd_decoder (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_valid,
    input  cmd_pkg::host_cmd_t cmd,
    input  logic               done,
    output logic               req_valid,
    output cmd_pkg::fill_req_t req,
    output logic               busy
);
    import cmd_pkg::*;

    width_t    avail_width;
    height_t   avail_height;
    logic      empty_area;
    logic      accept;
    fill_req_t next_req;

    // ******************************
    // clipping
    // ******************************
    assign avail_width  = width_t'(`PANEL_WIDTH) - width_t'(cmd.x1);
    assign avail_height = height_t'(`PANEL_HEIGHT) - height_t'(cmd.y1);

    assign empty_area = (cmd.width == '0) || (cmd.height == '0);

    // a blank always covers the panel while a fill may be empty
    assign accept = cmd_valid && !busy &&
                    ((cmd.opcode == op_blank) || !empty_area);

    always_comb begin
        if (cmd.opcode == op_blank) begin
            next_req.x1     = '0;
            next_req.y1     = '0;
            next_req.width  = width_t'(`PANEL_WIDTH);
            next_req.height = height_t'(`PANEL_HEIGHT);
            next_req.color  = '0;
        end else begin
            next_req.x1     = cmd.x1;
            next_req.y1     = cmd.y1;
            next_req.width  = (cmd.width > avail_width) ? avail_width : cmd.width;
            next_req.height = (cmd.height > avail_height) ? avail_height : cmd.height;
            next_req.color  = cmd.color;
        end
    end

    // ******************************
    // request strobe and busy level
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            req_valid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;    // falls the cycle after done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req <= next_req;
        end
    end

endmodule

//--- common/cmd_pkg.sv
// Drawing command types

`include "panel_cfg.svh"

package cmd_pkg;
    import panel_pkg::*;

    typedef enum logic {
        op_blank = 1'b0,
        op_fill  = 1'b1
    } opcode_t;

    // sizes need one more bit than the index so a full edge fits
    typedef logic [`COLUMN_BITS:0] width_t;
    typedef logic [`ROW_BITS:0]    height_t;

    // ******************************
    // command as the host sends it
    // ******************************
    typedef struct packed {
        opcode_t opcode;
        column_t x1;
        row_t    y1;
        width_t  width;
        height_t height;
        color_t  color;
    } host_cmd_t;

    // clipped request, width and height are never zero here
    typedef struct packed {
        column_t x1;
        row_t    y1;
        width_t  width;
        height_t height;
        color_t  color;
    } fill_req_t;

endpackage

//--- common/panel_pkg.sv
// Panel pixel and memory types

`include "panel_cfg.svh"

package panel_pkg;

    // ******************************
    // addressing
    // ******************************
    typedef logic [`ROW_BITS-1:0]       row_t;
    typedef logic [`COLUMN_BITS-1:0]    column_t;
    typedef logic [`PIXEL_SEL_BITS-1:0] pixel_sel_t;

    // red sits in the high byte and is stored at byte select 0
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } color_t;

    // ******************************
    // one byte write into the frame buffer
    // ******************************
    typedef struct packed {
        row_t       row;
        column_t    column;
        pixel_sel_t pixel;
        logic [7:0] data;
        logic       we;
    } mem_write_t;

endpackage

//--- common/panel_cfg.svh
// Panel geometry settings

`ifndef PANEL_CFG_SVH
`define PANEL_CFG_SVH

// ******************************
// panel size
// ******************************
`define PANEL_WIDTH       32
`define PANEL_HEIGHT      16
`define BYTES_PER_PIXEL   3    // red, green, blue

// ******************************
// derived address widths
// ******************************
`define COLUMN_BITS       5    // enough for PANEL_WIDTH columns
`define ROW_BITS          4    // enough for PANEL_HEIGHT rows
`define PIXEL_SEL_BITS    2    // enough for BYTES_PER_PIXEL bytes

`endif
